// File: design/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;   // instruction or data word
    typedef logic [2:0]  lc3b_reg;    // register index

    localparam int      num_regs = 8;
    localparam lc3b_reg link_reg = 3'd7;   // R7 takes the return pc

    typedef enum logic [3:0]
    {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,   // lc3x extensions live here
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [3:0]
    {
        alu_add,
        alu_and,
        alu_not,
        alu_passa,
        alu_passb,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_nand,
        alu_div,
        alu_mult,
        alu_sub,
        alu_xor,
        alu_or
    } lc3b_aluop;

    typedef struct packed
    {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       addr1mux_sel;
        logic [1:0] addr2mux_sel;
        logic       addr3mux_sel;
        logic       br_op;
        logic       jsr_op;
        logic       trap_op;
        logic       uncond_op;
        logic       jmp_op;
        logic       lshf;
        logic       sr2mux_sel;
        logic       dcacheR;
        logic       dcacheW;
        logic [1:0] wbmux_sel;
        logic       load_cc;
        logic       load_reg;
        logic       storemux_sel;   // sr2 reads the store data register
        lc3b_word   pc;
        logic       dcache_enable;
        logic       dest_mux_sel;   // dest forced to R7
        logic [1:0] alu_result_mux_sel;
        logic [1:0] d_mem_byte_sel;
        logic       stb_op;
        logic       ldi_op;
        logic       sti_op;
        logic       ldb_op;
        logic       sr1_needed;
        logic       sr2_needed;
        logic       dr_needed;
        logic       div_op;
        logic       mult_op;
        logic       sub_op;
        logic       xor_op;
        logic       or_op;
        logic       nor_op;
        logic       xnor_op;
        logic       nand_op;
        logic       ldbse_op;
    } lc3b_control_word;

    // what decode hands to execute
    typedef struct packed
    {
        logic             valid;
        lc3b_word         ir;
        lc3b_control_word ctrl;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_reg          dest;
    } id_ex_bundle;

endpackage : lc3b_types

// File: design/control_rom.sv
`timescale 1ns/1ns

module control_rom
(
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         ir11,
    input  logic                         ir5,
    input  logic                         ir4,
    input  logic [2:0]                   lc3x_control,
    input  logic [5:0]                   ldbseCheck,
    input  lc3b_types::lc3b_word         pc,
    output lc3b_types::lc3b_control_word ctrl
);
    import lc3b_types::*;

    logic alu_wr;   // register-register result to dr
    logic mem_rd;   // base+offset load path
    logic mem_wr;   // base+offset store path

    always_comb
    begin
        ctrl = '0;
        ctrl.opcode = opcode;
        ctrl.aluop = alu_passa;
        ctrl.pc = pc;
        alu_wr = 1'b0;
        mem_rd = 1'b0;
        mem_wr = 1'b0;

        case (opcode)
            op_add:
            begin
                ctrl.aluop = alu_add;
                ctrl.sr2mux_sel = ir5;        // imm5 form
                ctrl.sr2_needed = !ir5;
                alu_wr = 1'b1;
            end
            op_and:
            begin
                if (ir4)
                begin
                    ctrl.aluop = alu_nand;    // nand variant
                    ctrl.nand_op = 1'b1;
                end
                else
                    ctrl.aluop = alu_and;
                ctrl.sr2mux_sel = ir5;
                ctrl.sr2_needed = !ir5;
                alu_wr = 1'b1;
            end
            op_not:
            begin
                ctrl.aluop = alu_not;
                alu_wr = 1'b1;
            end
            op_shf:
            begin
                ctrl.alu_result_mux_sel = 2'b01;   // take the shifter
                alu_wr = 1'b1;
            end
            op_ldr:
            begin
                ctrl.lshf = 1'b1;
                mem_rd = 1'b1;
            end
            op_ldb:
            begin
                ctrl.d_mem_byte_sel = 2'b01;
                ctrl.ldb_op = 1'b1;
                mem_rd = 1'b1;
            end
            op_ldi:
            begin
                ctrl.lshf = 1'b1;
                ctrl.ldi_op = 1'b1;
                mem_rd = 1'b1;
            end
            op_str:
            begin
                ctrl.lshf = 1'b1;
                mem_wr = 1'b1;
            end
            op_stb:
            begin
                ctrl.stb_op = 1'b1;
                mem_wr = 1'b1;
            end
            op_sti:
            begin
                ctrl.lshf = 1'b1;
                ctrl.sti_op = 1'b1;
                mem_wr = 1'b1;
            end
            op_br:
            begin
                ctrl.addr2mux_sel = 2'b10;    // pcoffset9
                ctrl.lshf = 1'b1;
                ctrl.br_op = 1'b1;
            end
            op_lea:
            begin
                ctrl.addr2mux_sel = 2'b10;
                ctrl.lshf = 1'b1;
                ctrl.storemux_sel = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.dr_needed = 1'b1;
            end
            op_jmp:
            begin
                ctrl.jmp_op = 1'b1;           // also RET
                ctrl.uncond_op = 1'b1;
                ctrl.sr1_needed = 1'b1;
                if (ldbseCheck != 6'b000000)
                begin
                    // offset bits set means the byte load form
                    ctrl.d_mem_byte_sel = 2'b11;
                    ctrl.ldb_op = 1'b1;
                    mem_rd = 1'b1;
                end
            end
            op_jsr:
            begin
                ctrl.dest_mux_sel = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.uncond_op = 1'b1;
                ctrl.wbmux_sel = 2'b10;       // pc+2 into R7
                if (ir11)
                begin
                    ctrl.jsr_op = 1'b1;
                    ctrl.br_op = 1'b1;
                    ctrl.addr2mux_sel = 2'b11;   // pcoffset11
                    ctrl.lshf = 1'b1;
                end
                else
                begin
                    ctrl.jmp_op = 1'b1;       // JSRR jumps through base reg
                    ctrl.sr1_needed = 1'b1;
                end
            end
            op_trap:
            begin
                ctrl.dest_mux_sel = 1'b1;
                ctrl.load_reg = 1'b1;
                ctrl.trap_op = 1'b1;
                ctrl.wbmux_sel = 2'b10;
                ctrl.addr3mux_sel = 1'b1;     // zext trapvect8 << 1
                ctrl.dcache_enable = 1'b1;
                ctrl.dcacheR = 1'b1;
                ctrl.uncond_op = 1'b1;
            end
            op_rti:
            begin
                ctrl.load_reg = 1'b1;
                alu_wr = (lc3x_control != 3'b111);
                ctrl.sr2_needed = alu_wr;
                case (lc3x_control)
                    3'b000:
                    begin
                        ctrl.div_op = 1'b1;
                        ctrl.aluop = alu_div;
                    end
                    3'b001:
                    begin
                        ctrl.mult_op = 1'b1;
                        ctrl.aluop = alu_mult;
                    end
                    3'b010:
                    begin
                        ctrl.sub_op = 1'b1;
                        ctrl.aluop = alu_sub;
                    end
                    3'b011:
                    begin
                        ctrl.xor_op = 1'b1;
                        ctrl.aluop = alu_xor;
                    end
                    3'b100:
                    begin
                        ctrl.or_op = 1'b1;
                        ctrl.aluop = alu_or;
                    end
                    3'b101:
                        ctrl.nor_op = 1'b1;   // no alu code, flag only
                    3'b110:
                        ctrl.xnor_op = 1'b1;
                    default:
                    begin
                        // sign-extended byte load
                        ctrl.ldbse_op = 1'b1;
                        ctrl.ldb_op = 1'b1;
                        ctrl.d_mem_byte_sel = 2'b01;
                        mem_rd = 1'b1;
                    end
                endcase
            end
            default:
                ctrl = '0;                    // illegal opcode
        endcase

        if (alu_wr)
        begin
            ctrl.load_reg = 1'b1;
            ctrl.load_cc = 1'b1;
            ctrl.wbmux_sel = 2'b11;
            ctrl.sr1_needed = 1'b1;
            ctrl.dr_needed = 1'b1;
        end

        if (mem_rd)
        begin
            ctrl.addr1mux_sel = 1'b1;
            ctrl.addr2mux_sel = 2'b01;        // offset6
            ctrl.wbmux_sel = 2'b01;           // memory data
            ctrl.load_cc = 1'b1;
            ctrl.load_reg = 1'b1;
            ctrl.dcache_enable = 1'b1;
            ctrl.dcacheR = 1'b1;
            ctrl.sr1_needed = 1'b1;
            ctrl.dr_needed = 1'b1;
        end

        if (mem_wr)
        begin
            ctrl.addr1mux_sel = 1'b1;
            ctrl.addr2mux_sel = 2'b01;
            ctrl.storemux_sel = 1'b1;
            ctrl.aluop = alu_passb;           // store data through the alu
            ctrl.dcache_enable = 1'b1;
            ctrl.dcacheW = 1'b1;
            ctrl.sr1_needed = 1'b1;
            ctrl.dr_needed = 1'b1;
        end

        assert (!(ctrl.dcacheR && ctrl.dcacheW))
            else $error("control_rom: dcache read and write both set");
    end

endmodule : control_rom

// File: design/regfile.sv
`timescale 1ns/1ns

module regfile
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_reg  src1,
    input  lc3b_types::lc3b_reg  src2,
    input  lc3b_types::lc3b_word wdata,
    output lc3b_types::lc3b_word rdata1,
    output lc3b_types::lc3b_word rdata2
);
    import lc3b_types::*;

    lc3b_word regs [num_regs];

    always_ff @(posedge clk)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (load)
            regs[dest] <= wdata;
    end

    // no bypass, a same-cycle write is seen next cycle
    assign rdata1 = regs[src1];
    assign rdata2 = regs[src2];

    wb_dest_known: assert property (@(posedge clk) disable iff (rst)
        load |-> !$isunknown(dest))
        else $error("regfile: write with unknown dest");

endmodule : regfile

// File: design/hazard_detect.sv
`timescale 1ns/1ns

module hazard_detect
(
    input  logic                         instr_valid,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_reg          src1,
    input  lc3b_types::lc3b_reg          src2,
    input  lc3b_types::id_ex_bundle      ex_bundle,
    output logic                         stall
);

    logic ex_is_load;
    logic sr2_check;
    logic sr1_hit;
    logic sr2_hit;

    // load in execute, data not ready before mem
    assign ex_is_load = ex_bundle.valid
                     && ex_bundle.ctrl.dcacheR
                     && ex_bundle.ctrl.load_reg;

    // stores read their data register on the sr2 port
    assign sr2_check = ctrl.storemux_sel ? ctrl.dr_needed : ctrl.sr2_needed;

    assign sr1_hit = ctrl.sr1_needed && (ex_bundle.dest == src1);
    assign sr2_hit = sr2_check && (ex_bundle.dest == src2);

    assign stall = instr_valid && ex_is_load && (sr1_hit || sr2_hit);

endmodule : hazard_detect

// File: design/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         instr_valid,
    input  lc3b_types::lc3b_word         ir,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word         sr1_data,
    input  lc3b_types::lc3b_word         sr2_data,
    input  lc3b_types::lc3b_reg          dest,
    output lc3b_types::id_ex_bundle      bundle
);
    import lc3b_types::*;

    id_ex_bundle next_bundle;
    logic        take;

    assign take = instr_valid && !stall;

    always_comb
    begin
        next_bundle = '0;                    // bubble unless taken
        if (take)
        begin
            next_bundle.valid = 1'b1;
            next_bundle.ir = ir;
            next_bundle.ctrl = ctrl;
            next_bundle.sr1_data = sr1_data;
            next_bundle.sr2_data = sr2_data;
            next_bundle.dest = dest;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            bundle <= '0;
        else
            bundle <= next_bundle;
    end

    // the bubble frees the load so a stall lasts one cycle
    stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
        stall |=> !stall)
        else $error("id_ex_reg: stall held for two cycles");

endmodule : id_ex_reg

// File: design/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
(
    input  logic                    clk,
    input  logic                    rst,
    input  lc3b_types::lc3b_word    instr,
    input  logic                    instr_valid,
    input  lc3b_types::lc3b_word    pc,
    input  logic                    wb_load,
    input  lc3b_types::lc3b_reg     wb_dest,
    input  lc3b_types::lc3b_word    wb_data,
    output logic                    stall,
    output lc3b_types::id_ex_bundle ex_out
);
    import lc3b_types::*;

    lc3b_opcode       opcode;
    lc3b_control_word ctrl;
    lc3b_reg          src1;
    lc3b_reg          src2;
    lc3b_reg          dest;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;

    assign opcode = lc3b_opcode'(instr[15:12]);
    assign src1 = instr[8:6];
    assign src2 = ctrl.storemux_sel ? instr[11:9] : instr[2:0];   // store data reg
    assign dest = ctrl.dest_mux_sel ? link_reg : instr[11:9];

    control_rom i_control_rom
    (
        .opcode       (opcode),
        .ir11         (instr[11]),
        .ir5          (instr[5]),
        .ir4          (instr[4]),
        .lc3x_control (instr[5:3]),
        .ldbseCheck   (instr[5:0]),
        .pc           (pc),
        .ctrl         (ctrl)
    );

    regfile i_regfile
    (
        .clk    (clk),
        .rst    (rst),
        .load   (wb_load),
        .dest   (wb_dest),
        .src1   (src1),
        .src2   (src2),
        .wdata  (wb_data),
        .rdata1 (sr1_data),
        .rdata2 (sr2_data)
    );

    // compares against what id_ex_reg currently holds
    hazard_detect i_hazard_detect
    (
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .src1        (src1),
        .src2        (src2),
        .ex_bundle   (ex_out),
        .stall       (stall)
    );

    id_ex_reg i_id_ex_reg
    (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .ir          (instr),
        .ctrl        (ctrl),
        .sr1_data    (sr1_data),
        .sr2_data    (sr2_data),
        .dest        (dest),
        .bundle      (ex_out)
    );

endmodule : decode_stage

// File: verif/decode_model.svh
`ifndef decode_model_svh
`define decode_model_svh

// reference control word, built per field from the instruction classes
function automatic lc3b_control_word model_ctrl(input lc3b_word ir, input lc3b_word pc_in);
    lc3b_control_word c;
    lc3b_opcode       op;
    logic [2:0]       x;
    logic             ir11;
    logic             jmp_byte;
    logic             alu;
    logic             ld;
    logic             st;
    op = lc3b_opcode'(ir[15:12]);
    x = ir[5:3];
    ir11 = ir[11];
    jmp_byte = (op == op_jmp) && (ir[5:0] != 6'd0);
    alu = (op == op_add) || (op == op_and) || (op == op_not) || (op == op_shf)
       || ((op == op_rti) && (x != 3'd7));
    ld = (op == op_ldr) || (op == op_ldb) || (op == op_ldi) || jmp_byte
      || ((op == op_rti) && (x == 3'd7));
    st = (op == op_str) || (op == op_stb) || (op == op_sti);

    c = '0;
    c.opcode = op;
    c.pc = pc_in;
    c.aluop = st ? alu_passb : alu_passa;
    case (op)
        op_add: c.aluop = alu_add;
        op_and: c.aluop = ir[4] ? alu_nand : alu_and;
        op_not: c.aluop = alu_not;
        op_rti:
        begin
            case (x)
                3'd0: c.aluop = alu_div;
                3'd1: c.aluop = alu_mult;
                3'd2: c.aluop = alu_sub;
                3'd3: c.aluop = alu_xor;
                3'd4: c.aluop = alu_or;
                default: c.aluop = alu_passa;   // nor, xnor, ldbse
            endcase
        end
        default: ;
    endcase

    c.addr1mux_sel = ld || st;
    if (ld || st)
        c.addr2mux_sel = 2'b01;
    else if ((op == op_br) || (op == op_lea))
        c.addr2mux_sel = 2'b10;
    else if ((op == op_jsr) && ir11)
        c.addr2mux_sel = 2'b11;
    c.addr3mux_sel = (op == op_trap);
    c.br_op = (op == op_br) || ((op == op_jsr) && ir11);
    c.jsr_op = (op == op_jsr) && ir11;
    c.trap_op = (op == op_trap);
    c.uncond_op = (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    c.jmp_op = (op == op_jmp) || ((op == op_jsr) && !ir11);
    c.lshf = (op == op_ldr) || (op == op_ldi) || (op == op_str) || (op == op_sti)
          || (op == op_br) || (op == op_lea) || ((op == op_jsr) && ir11);
    c.sr2mux_sel = ((op == op_add) || (op == op_and)) && ir[5];
    c.dcacheR = ld || (op == op_trap);
    c.dcacheW = st;
    if (ld)
        c.wbmux_sel = 2'b01;
    else if (alu)
        c.wbmux_sel = 2'b11;
    else if ((op == op_jsr) || (op == op_trap))
        c.wbmux_sel = 2'b10;   // return pc
    c.load_cc = ld || alu || (op == op_lea);
    c.load_reg = ld || alu || (op == op_lea) || (op == op_jsr) || (op == op_trap)
              || (op == op_rti);
    c.storemux_sel = st || (op == op_lea);
    c.dcache_enable = ld || st || (op == op_trap);
    c.dest_mux_sel = (op == op_jsr) || (op == op_trap);
    c.alu_result_mux_sel = (op == op_shf) ? 2'b01 : 2'b00;
    if (jmp_byte)
        c.d_mem_byte_sel = 2'b11;
    else if ((op == op_ldb) || ((op == op_rti) && (x == 3'd7)))
        c.d_mem_byte_sel = 2'b01;
    c.stb_op = (op == op_stb);
    c.ldi_op = (op == op_ldi);
    c.sti_op = (op == op_sti);
    c.ldb_op = (op == op_ldb) || jmp_byte || ((op == op_rti) && (x == 3'd7));
    c.sr1_needed = ld || st || alu || (op == op_jmp) || ((op == op_jsr) && !ir11);
    c.sr2_needed = (((op == op_add) || (op == op_and)) && !ir[5])
                || ((op == op_rti) && (x != 3'd7));
    c.dr_needed = ld || st || alu || (op == op_lea);
    c.div_op = (op == op_rti) && (x == 3'd0);
    c.mult_op = (op == op_rti) && (x == 3'd1);
    c.sub_op = (op == op_rti) && (x == 3'd2);
    c.xor_op = (op == op_rti) && (x == 3'd3);
    c.or_op = (op == op_rti) && (x == 3'd4);
    c.nor_op = (op == op_rti) && (x == 3'd5);
    c.xnor_op = (op == op_rti) && (x == 3'd6);
    c.nand_op = (op == op_and) && ir[4];
    c.ldbse_op = (op == op_rti) && (x == 3'd7);
    return c;
endfunction

// R7 for the linking instructions
function automatic lc3b_reg model_dest(input lc3b_word ir);
    lc3b_opcode op;
    op = lc3b_opcode'(ir[15:12]);
    if ((op == op_jsr) || (op == op_trap))
        return link_reg;
    return ir[11:9];
endfunction

function automatic logic model_stall(input logic v, input lc3b_control_word c,
                                     input lc3b_word ir, input id_ex_bundle held);
    lc3b_reg s2;
    logic    hit1;
    logic    hit2;
    s2 = c.storemux_sel ? ir[11:9] : ir[2:0];
    hit1 = c.sr1_needed && (held.dest == ir[8:6]);
    hit2 = (c.storemux_sel ? c.dr_needed : c.sr2_needed) && (held.dest == s2);
    return v && held.valid && held.ctrl.dcacheR && held.ctrl.load_reg && (hit1 || hit2);
endfunction

`endif

// File: verif/decode_stage_tb.sv
`timescale 1ns/1ns

module decode_stage_tb;
    import lc3b_types::*;
    `include "decode_model.svh"

    localparam int n_ctrl = 2000;
    localparam int n_regs = 500;
    localparam int n_dest = 20;
    localparam int n_haz = 50;
    // each issue can take a stall cycle, directed groups are longer
    localparam int total_cycles = 10 + 2 * n_ctrl + 2 * n_regs + 12 * n_dest
                                + 16 * n_haz + 10;
    localparam int max_cycles = 2 * total_cycles;

    logic        clk = 1'b0;
    logic        rst;
    lc3b_word    instr;
    logic        instr_valid;
    lc3b_word    pc;
    logic        wb_load;
    lc3b_reg     wb_dest;
    lc3b_word    wb_data;
    logic        stall;
    id_ex_bundle ex_out;

    id_ex_bundle exp_bundle;          // what the register should hold next
    lc3b_word    shadow [num_regs];
    logic        last_stall;
    integer      seed = 40946;
    int          cycle_count = 0;

    decode_stage i_decode_stage
    (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .wb_load     (wb_load),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .stall       (stall),
        .ex_out      (ex_out)
    );

    always #4 clk = !clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout, run did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_bundle();
        check_value("bundle_valid", exp_bundle.valid, ex_out.valid);
        check_value("bundle_ir", exp_bundle.ir, ex_out.ir);
        check_value("bundle_ctrl", exp_bundle.ctrl, ex_out.ctrl);
        check_value("bundle_sr1_data", exp_bundle.sr1_data, ex_out.sr1_data);
        check_value("bundle_sr2_data", exp_bundle.sr2_data, ex_out.sr2_data);
        check_value("bundle_dest", exp_bundle.dest, ex_out.dest);
    endtask

    // one clock of stimulus, checks last edge's bundle and this cycle's stall
    task automatic run_cycle(input logic v, input lc3b_word ir, input lc3b_word pc_in,
                             input logic wl, input lc3b_reg wd, input lc3b_word wdat);
        lc3b_control_word mc;
        logic             ms;
        lc3b_reg          s2;
        @(negedge clk);
        compare_bundle();
        instr_valid = v;
        instr = ir;
        pc = pc_in;
        wb_load = wl;
        wb_dest = wd;
        wb_data = wdat;
        mc = model_ctrl(ir, pc_in);
        ms = model_stall(v, mc, ir, exp_bundle);
        s2 = mc.storemux_sel ? ir[11:9] : ir[2:0];
        #2;
        check_value("stall", ms, stall);
        exp_bundle = '0;
        if (v && !ms)
        begin
            exp_bundle.valid = 1'b1;
            exp_bundle.ir = ir;
            exp_bundle.ctrl = mc;
            exp_bundle.sr1_data = shadow[ir[8:6]];   // old value on same-cycle write
            exp_bundle.sr2_data = shadow[s2];
            exp_bundle.dest = model_dest(ir);
        end
        if (wl)
            shadow[wd] = wdat;
        last_stall = ms;
    endtask

    task automatic idle();
        run_cycle(1'b0, 16'h0000, 16'h0000, 1'b0, 3'd0, 16'h0000);
    endtask

    // hold the instruction until it gets past a stall
    task automatic issue(input lc3b_word ir, input lc3b_word pc_in, input logic wl,
                         input lc3b_reg wd, input lc3b_word wdat);
        run_cycle(1'b1, ir, pc_in, wl, wd, wdat);
        while (last_stall)
            run_cycle(1'b1, ir, pc_in, wl, wd, wdat);
    endtask

    task automatic dest_case(input lc3b_word ir, input lc3b_reg expected);
        issue(ir, 16'h3000, 1'b0, 3'd0, 16'h0000);
        idle();
        check_value("dest", expected, ex_out.dest);
    endtask

    task automatic hazard_cases();
        lc3b_reg  d;
        lc3b_reg  other;
        lc3b_word ldr_ir;
        lc3b_word use_ir;
        d = $random(seed);
        other = d + 3'd1;
        ldr_ir = {4'b0110, d, other, 6'($random(seed))};
        use_ir = {4'b0001, other, d, 3'b000, other};    // add reads d on sr1

        issue(ldr_ir, 16'h3000, 1'b0, 3'd0, 16'h0000);
        run_cycle(1'b1, use_ir, 16'h3002, 1'b0, 3'd0, 16'h0000);
        check_value("load_use_stall", 1, stall);
        run_cycle(1'b1, use_ir, 16'h3002, 1'b0, 3'd0, 16'h0000);
        check_value("stall_clears", 0, stall);
        check_value("bubble_after_stall", 0, ex_out.valid);
        idle();
        check_value("held_instr_valid", 1, ex_out.valid);
        check_value("held_instr_ir", use_ir, ex_out.ir);

        // imm5 form, d only sits in the immediate
        issue(ldr_ir, 16'h3004, 1'b0, 3'd0, 16'h0000);
        run_cycle(1'b1, {4'b0001, other, other, 3'b100, d}, 16'h3006, 1'b0, 3'd0, 16'h0);
        check_value("unneeded_src_no_stall", 0, stall);

        issue({4'b0001, d, other, 3'b000, other}, 16'h3008, 1'b0, 3'd0, 16'h0000);
        run_cycle(1'b1, use_ir, 16'h300a, 1'b0, 3'd0, 16'h0000);
        check_value("non_load_no_stall", 0, stall);

        issue(ldr_ir, 16'h300c, 1'b0, 3'd0, 16'h0000);
        run_cycle(1'b0, use_ir, 16'h300e, 1'b0, 3'd0, 16'h0000);
        check_value("invalid_no_stall", 0, stall);
        idle();
        check_value("invalid_bubble", 0, ex_out.valid);
    endtask

    initial
    begin
        lc3b_word ir_r;
        lc3b_word pc_r;
        lc3b_word data_r;
        lc3b_reg  wd_r;
        logic     wl_r;
        logic [1:0] kind;
        rst = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        pc = '0;
        wb_load = 1'b0;
        wb_dest = '0;
        wb_data = '0;
        exp_bundle = '0;
        last_stall = 1'b0;
        for (int r = 0; r < num_regs; r++)
            shadow[r] = '0;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_value("reset_valid", 0, ex_out.valid);
        check_value("reset_ctrl", 0, ex_out.ctrl);
        check_value("reset_stall", 0, stall);

        // random opcodes and fields, random writebacks alongside
        for (int i = 0; i < n_ctrl; i++)
        begin
            ir_r = $random(seed);
            pc_r = $random(seed);
            wl_r = $random(seed);
            wd_r = $random(seed);
            data_r = $random(seed);
            issue(ir_r, pc_r, wl_r, wd_r, data_r);
        end

        // reads of registers written in the same cycle, store data on sr2
        for (int i = 0; i < n_regs; i++)
        begin
            ir_r = $random(seed);
            kind = $random(seed);
            case (kind)
                2'd0: ir_r = {4'b0001, ir_r[11:6], 3'b000, ir_r[2:0]};
                2'd1: ir_r = {4'b0111, ir_r[11:0]};
                2'd2: ir_r = {4'b0011, ir_r[11:0]};
                default: ir_r = {4'b1011, ir_r[11:0]};
            endcase
            wd_r = ir_r[0] ? ir_r[8:6] : ir_r[11:9];
            data_r = $random(seed);
            issue(ir_r, 16'h4000, 1'b1, wd_r, data_r);
        end

        for (int i = 0; i < n_dest; i++)
        begin
            ir_r = $random(seed);
            dest_case({4'b0100, 1'b1, ir_r[10:0]}, link_reg);     // jsr
            dest_case({4'b0100, 1'b0, ir_r[10:0]}, link_reg);     // jsrr
            dest_case({4'b1111, ir_r[11:0]}, link_reg);
            dest_case({4'b0001, ir_r[11:0]}, ir_r[11:9]);
        end

        for (int i = 0; i < n_haz; i++)
            hazard_cases();

        idle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : decode_stage_tb

// File: sources.f
+incdir+verif
design/lc3b_types.sv
design/control_rom.sv
design/regfile.sv
design/hazard_detect.sv
design/id_ex_reg.sv
design/decode_stage.sv
verif/decode_stage_tb.sv

// File: Bender.yml
package:
  name: lc3b_decode

sources:
  - design/lc3b_types.sv
  - design/control_rom.sv
  - design/regfile.sv
  - design/hazard_detect.sv
  - design/id_ex_reg.sv
  - design/decode_stage.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/decode_stage_tb.sv
